// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // ============================================================
    // Word geometry
    // ============================================================
    localparam int XLEN      = 32;  // Processor word width
    localparam int BYTE_BITS = 2;   // Byte select bits inside a word

    // ============================================================
    // Controller states
    // ============================================================
    typedef enum logic [2:0] {
        ST_INIT,       // Sweep of valid and dirty bits after reset
        ST_IDLE,       // Waiting for a processor request
        ST_LOOKUP,     // Tag compare on the synchronous read
        ST_WRITEBACK,  // Dirty victim goes out to memory
        ST_REFILL,     // Waiting for the line from memory
        ST_DONE        // Install the refilled line and answer
    } cache_state_e;

    // Memory port opcode
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire

// ==== hw/dcache_fifo_repl.sv ====
`default_nettype none

module dcache_fifo_repl
#(
    parameter  int N_WAYS = 4,
    parameter  int N_SETS = 16,
    localparam int WAY_W  = $clog2(N_WAYS),
    localparam int SET_W  = $clog2(N_SETS)
)
(
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire [SET_W-1:0]  set_i,         // Set of the current request
    input  wire              advance_i,     // One refill done in set_i
    output logic [WAY_W-1:0] victim_way_o   // Next way to fill in set_i
);

    // One round-robin pointer per set, oldest fill first
    logic [WAY_W-1:0] ptr_q [N_SETS];

    assign victim_way_o = ptr_q[set_i];  // Combinational lookup

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                ptr_q[s] <= '0;  // Empty ways fill from way 0 up
        end
        else if (advance_i)
        begin
            // Wrap after the last way
            if (ptr_q[set_i] == WAY_W'(N_WAYS - 1))
                ptr_q[set_i] <= '0;
            else
                ptr_q[set_i] <= ptr_q[set_i] + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dcache_way_array.sv ====
`default_nettype none

module dcache_way_array
    import dcache_pkg::*;
#(
    parameter  int N_WAYS     = 4,
    parameter  int N_SETS     = 16,
    parameter  int LINE_WORDS = 4,
    localparam int WAY_W      = $clog2(N_WAYS),
    localparam int SET_W      = $clog2(N_SETS),
    localparam int OFF_W      = $clog2(LINE_WORDS),
    localparam int TAG_W      = XLEN - SET_W - OFF_W - BYTE_BITS,
    localparam int LINE_W     = LINE_WORDS * XLEN
)
(
    input  wire               clk_i,
    input  wire               rst_i,
    input  wire [SET_W-1:0]   set_i,          // Read and write index
    input  wire [TAG_W-1:0]   tag_i,          // Compare tag, also the write tag
    input  wire               line_we_i,      // Write tag, line and flags
    input  wire [WAY_W-1:0]   way_i,          // Way to write
    input  wire [LINE_W-1:0]  line_i,
    input  wire               dirty_i,        // Dirty value on a write
    input  wire               clear_i,        // Zero all flags of set_i
    input  wire [WAY_W-1:0]   victim_way_i,
    output logic              hit_o,
    output logic [WAY_W-1:0]  hit_way_o,
    output logic [LINE_W-1:0] hit_line_o,
    output logic [TAG_W-1:0]  victim_tag_o,
    output logic [LINE_W-1:0] victim_line_o,
    output logic              victim_dirty_o
);

    // ============================================================
    // Storage
    // ============================================================
    logic [TAG_W-1:0]  tag_mem   [N_WAYS][N_SETS];
    logic [LINE_W-1:0] data_mem  [N_WAYS][N_SETS];
    logic [N_WAYS-1:0] valid_mem [N_SETS];  // One bit per way
    logic [N_WAYS-1:0] dirty_mem [N_SETS];

    // Registered read of the indexed set
    logic [TAG_W-1:0]  tag_q  [N_WAYS];
    logic [LINE_W-1:0] data_q [N_WAYS];
    logic [N_WAYS-1:0] valid_q;
    logic [N_WAYS-1:0] dirty_q;

    // Tag and data RAM, read-before-write per way
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (line_we_i && way_i == WAY_W'(w))
            begin
                tag_mem[w][set_i]  <= tag_i;
                data_mem[w][set_i] <= line_i;
            end
            tag_q[w]  <= tag_mem[w][set_i];
            data_q[w] <= data_mem[w][set_i];
        end
    end

    // Flag RAM, cleared set by set during the init sweep
    always_ff @(posedge clk_i)
    begin
        if (clear_i)
        begin
            valid_mem[set_i] <= '0;
            dirty_mem[set_i] <= '0;
        end
        else if (line_we_i)
        begin
            valid_mem[set_i][way_i] <= 1'b1;     // Installed or updated line
            dirty_mem[set_i][way_i] <= dirty_i;  // Stores mark the line dirty
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            valid_q <= '0;  // No stale hit straight out of reset
            dirty_q <= '0;
        end
        else
        begin
            valid_q <= valid_mem[set_i];
            dirty_q <= dirty_mem[set_i];
        end
    end

    // ============================================================
    // Hit detection and victim readout
    // ============================================================
    always_comb
    begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (valid_q[w] && tag_q[w] == tag_i)
            begin
                hit_o     = 1'b1;
                hit_way_o = WAY_W'(w);  // At most one way matches
            end
        end
    end

    assign hit_line_o     = data_q[hit_way_o];
    assign victim_tag_o   = tag_q[victim_way_i];
    assign victim_line_o  = data_q[victim_way_i];
    assign victim_dirty_o = dirty_q[victim_way_i];  // Dirty implies valid

endmodule

`default_nettype wire

// ==== hw/dcache_word_merge.sv ====
`default_nettype none

module dcache_word_merge
    import dcache_pkg::*;
#(
    parameter  int LINE_WORDS = 4,
    localparam int OFF_W      = $clog2(LINE_WORDS),
    localparam int LINE_W     = LINE_WORDS * XLEN
)
(
    input  wire [LINE_W-1:0]  line_i,    // Hit line or refill buffer
    input  wire [OFF_W-1:0]   offset_i,  // Word index inside the line
    input  wire [XLEN-1:0]    wdata_i,   // Store data, already lane aligned
    input  wire [XLEN/8-1:0]  be_i,      // All zero for loads
    output logic [XLEN-1:0]   word_o,    // Addressed word for loads
    output logic [LINE_W-1:0] line_o     // Line with the store merged in
);

    logic [XLEN-1:0] new_word;  // Addressed word after the merge

    // Word 0 sits in the low bits
    assign word_o = line_i[offset_i*XLEN +: XLEN];

    // Byte lane merge
    always_comb
    begin
        for (int b = 0; b < XLEN/8; b++)
        begin
            if (be_i[b])
                new_word[8*b +: 8] = wdata_i[8*b +: 8];
            else
                new_word[8*b +: 8] = word_o[8*b +: 8];
        end
    end

    // Put the word back, other words untouched
    always_comb
    begin
        line_o = line_i;
        line_o[offset_i*XLEN +: XLEN] = new_word;
    end

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter  int N_WAYS     = 4,
    parameter  int N_SETS     = 16,
    parameter  int LINE_WORDS = 4,
    localparam int WAY_W      = $clog2(N_WAYS),
    localparam int SET_W      = $clog2(N_SETS),
    localparam int OFF_W      = $clog2(LINE_WORDS),
    localparam int TAG_W      = XLEN - SET_W - OFF_W - BYTE_BITS,
    localparam int LINE_W     = LINE_WORDS * XLEN
)
(
    input  wire               clk_i,
    input  wire               rst_i,
    // Processor port
    input  wire               p_strobe_i,
    input  wire               p_rw_i,          // 1 for store
    input  wire [XLEN-1:0]    p_addr_i,
    input  wire [XLEN-1:0]    p_wdata_i,
    input  wire [XLEN/8-1:0]  p_be_i,
    output logic [XLEN-1:0]   p_rdata_o,
    output logic              p_ready_o,
    // Memory port
    output logic              m_strobe_o,
    output mem_op_e           m_op_o,
    output logic [XLEN-1:0]   m_addr_o,
    output logic [LINE_W-1:0] m_wdata_o,
    input  wire [LINE_W-1:0]  m_rdata_i,
    input  wire               m_ready_i,
    // Way array
    output logic [SET_W-1:0]  set_o,
    output logic [TAG_W-1:0]  tag_o,
    output logic              line_we_o,
    output logic [WAY_W-1:0]  way_o,
    output logic [LINE_W-1:0] line_o,
    output logic              dirty_o,
    output logic              clear_o,
    input  wire               hit_i,
    input  wire [WAY_W-1:0]   hit_way_i,
    input  wire [LINE_W-1:0]  hit_line_i,
    input  wire [TAG_W-1:0]   victim_tag_i,
    input  wire [LINE_W-1:0]  victim_line_i,
    input  wire               victim_dirty_i,
    // Replacement
    output logic              repl_advance_o,
    input  wire [WAY_W-1:0]   victim_way_i,
    // Word merge
    output logic [LINE_W-1:0] merge_src_line_o,
    output logic [OFF_W-1:0]  offset_o,
    output logic [XLEN-1:0]   wdata_o,
    output logic [XLEN/8-1:0] be_o,
    input  wire [XLEN-1:0]    rdata_word_i,
    input  wire [LINE_W-1:0]  merged_line_i
);

    cache_state_e      state_q, state_d;
    logic [SET_W-1:0]  sweep_q;            // Init sweep index
    logic              rw_q;               // Registered request
    logic [XLEN-1:0]   addr_q;
    logic [XLEN-1:0]   wdata_q;
    logic [XLEN/8-1:0] be_q;
    logic [LINE_W-1:0] fill_q;             // Refill buffer
    logic [SET_W-1:0]  req_set;
    logic [TAG_W-1:0]  req_tag;
    logic              wb_enter, rf_enter;  // State entry strobes

    assign req_set = addr_q[BYTE_BITS+OFF_W +: SET_W];
    assign req_tag = addr_q[XLEN-1 -: TAG_W];

    // ============================================================
    // State machine
    // ============================================================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_INIT:
                if (sweep_q == SET_W'(N_SETS - 1))
                    state_d = ST_IDLE;
            ST_IDLE:
                if (p_strobe_i)
                    state_d = ST_LOOKUP;
            ST_LOOKUP:
                if (hit_i)
                    state_d = ST_IDLE;
                else if (victim_dirty_i)
                    state_d = ST_WRITEBACK;  // Victim must go out first
                else
                    state_d = ST_REFILL;
            ST_WRITEBACK:
                if (m_ready_i)
                    state_d = ST_REFILL;
            ST_REFILL:
                if (m_ready_i)
                    state_d = ST_DONE;
            ST_DONE:
                state_d = ST_IDLE;
            default:
                state_d = ST_INIT;
        endcase
    end

    assign wb_enter = (state_q == ST_LOOKUP) && (state_d == ST_WRITEBACK);
    assign rf_enter = (state_q != ST_REFILL) && (state_d == ST_REFILL);

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= ST_INIT;
            sweep_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == ST_INIT)
                sweep_q <= sweep_q + 1'b1;
        end
    end

    // Request capture on the accepting edge
    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_IDLE && p_strobe_i)
        begin
            rw_q    <= p_rw_i;
            addr_q  <= p_addr_i;
            wdata_q <= p_wdata_i;
            be_q    <= p_be_i;
        end
        if (state_q == ST_REFILL && m_ready_i)
            fill_q <= m_rdata_i;  // Line from memory
    end

    // ============================================================
    // Memory port, one strobe per transaction
    // ============================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_op_o     <= MEM_READ;
        end
        else
        begin
            m_strobe_o <= wb_enter || rf_enter;
            if (wb_enter)
                m_op_o <= MEM_WRITE;
            else if (rf_enter)
                m_op_o <= MEM_READ;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wb_enter)
        begin
            m_addr_o  <= {victim_tag_i, req_set, {(OFF_W+BYTE_BITS){1'b0}}};
            m_wdata_o <= victim_line_i;  // Held until m_ready_i
        end
        else if (rf_enter)
            m_addr_o <= {req_tag, req_set, {(OFF_W+BYTE_BITS){1'b0}}};
    end

    // ============================================================
    // Array writes and processor answer
    // ============================================================
    always_comb
    begin
        set_o          = req_set;
        line_we_o      = 1'b0;
        way_o          = hit_way_i;
        line_o         = merged_line_i;
        dirty_o        = rw_q;  // Only stores leave a dirty line
        clear_o        = 1'b0;
        repl_advance_o = 1'b0;
        p_ready_o      = 1'b0;
        case (state_q)
            ST_INIT:
            begin
                set_o   = sweep_q;
                clear_o = 1'b1;
            end
            ST_IDLE:
                set_o = p_addr_i[BYTE_BITS+OFF_W +: SET_W];  // Read starts at accept
            ST_LOOKUP:
            begin
                p_ready_o = hit_i;
                line_we_o = hit_i && rw_q;  // Store hit
            end
            ST_DONE:
            begin
                line_we_o      = 1'b1;
                way_o          = victim_way_i;
                line_o         = rw_q ? merged_line_i : fill_q;
                repl_advance_o = 1'b1;
                p_ready_o      = 1'b1;
            end
            default: ;
        endcase
    end

    assign merge_src_line_o = (state_q == ST_DONE) ? fill_q : hit_line_i;
    assign tag_o            = req_tag;
    assign offset_o         = addr_q[BYTE_BITS +: OFF_W];
    assign wdata_o          = wdata_q;
    assign be_o             = rw_q ? be_q : '0;  // Loads leave the line as is
    assign p_rdata_o        = rdata_word_i;

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter  int N_WAYS     = 4,
    parameter  int N_SETS     = 16,
    parameter  int LINE_WORDS = 4,   // 128-bit line
    localparam int WAY_W      = $clog2(N_WAYS),
    localparam int SET_W      = $clog2(N_SETS),
    localparam int OFF_W      = $clog2(LINE_WORDS),
    localparam int TAG_W      = XLEN - SET_W - OFF_W - BYTE_BITS,
    localparam int LINE_W     = LINE_WORDS * XLEN
)
(
    input  wire               clk_i,
    input  wire               rst_i,
    // Processor port
    input  wire               p_strobe_i,
    input  wire               p_rw_i,
    input  wire [XLEN-1:0]    p_addr_i,
    input  wire [XLEN-1:0]    p_wdata_i,
    input  wire [XLEN/8-1:0]  p_be_i,
    output logic [XLEN-1:0]   p_rdata_o,
    output logic              p_ready_o,
    // Memory port
    output logic              m_strobe_o,
    output mem_op_e           m_op_o,
    output logic [XLEN-1:0]   m_addr_o,
    output logic [LINE_W-1:0] m_wdata_o,
    input  wire [LINE_W-1:0]  m_rdata_i,
    input  wire               m_ready_i
);

    // ============================================================
    // Internal wiring
    // ============================================================
    logic [SET_W-1:0]  set;
    logic [TAG_W-1:0]  tag;
    logic              line_we, dirty, clear;
    logic [WAY_W-1:0]  way, hit_way, victim_way;
    logic [LINE_W-1:0] wr_line, hit_line, victim_line;
    logic              hit, victim_dirty, repl_advance;
    logic [TAG_W-1:0]  victim_tag;
    logic [LINE_W-1:0] merge_src_line, merged_line;
    logic [OFF_W-1:0]  offset;
    logic [XLEN-1:0]   wdata, rdata_word;
    logic [XLEN/8-1:0] be;

    dcache_ctrl #(.N_WAYS(N_WAYS), .N_SETS(N_SETS), .LINE_WORDS(LINE_WORDS)) u_ctrl (
        .clk_i, .rst_i,
        .p_strobe_i, .p_rw_i, .p_addr_i, .p_wdata_i, .p_be_i, .p_rdata_o, .p_ready_o,
        .m_strobe_o, .m_op_o, .m_addr_o, .m_wdata_o, .m_rdata_i, .m_ready_i,
        .set_o(set), .tag_o(tag), .line_we_o(line_we), .way_o(way), .line_o(wr_line),
        .dirty_o(dirty), .clear_o(clear),
        .hit_i(hit), .hit_way_i(hit_way), .hit_line_i(hit_line),
        .victim_tag_i(victim_tag), .victim_line_i(victim_line),
        .victim_dirty_i(victim_dirty),
        .repl_advance_o(repl_advance), .victim_way_i(victim_way),
        .merge_src_line_o(merge_src_line), .offset_o(offset), .wdata_o(wdata), .be_o(be),
        .rdata_word_i(rdata_word), .merged_line_i(merged_line)
    );

    dcache_way_array #(.N_WAYS(N_WAYS), .N_SETS(N_SETS), .LINE_WORDS(LINE_WORDS)) u_ways (
        .clk_i, .rst_i,
        .set_i(set), .tag_i(tag), .line_we_i(line_we), .way_i(way), .line_i(wr_line),
        .dirty_i(dirty), .clear_i(clear), .victim_way_i(victim_way),
        .hit_o(hit), .hit_way_o(hit_way), .hit_line_o(hit_line),
        .victim_tag_o(victim_tag), .victim_line_o(victim_line),
        .victim_dirty_o(victim_dirty)
    );

    // Victim pointer follows the same set index as the array
    dcache_fifo_repl #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) u_repl (
        .clk_i, .rst_i,
        .set_i(set), .advance_i(repl_advance), .victim_way_o(victim_way)
    );

    dcache_word_merge #(.LINE_WORDS(LINE_WORDS)) u_merge (
        .line_i(merge_src_line), .offset_i(offset), .wdata_i(wdata), .be_i(be),
        .word_o(rdata_word), .line_o(merged_line)
    );

endmodule

`default_nettype wire

// ==== tb/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model
    import dcache_pkg::*;
#(
    parameter  int          LINE_WORDS = 4,
    parameter  int          MEM_WORDS  = 4096,           // 16 KiB backing store
    parameter  logic [31:0] PATTERN    = 32'h5A3C_96E1,  // Fill XOR constant
    localparam int          LINE_W     = LINE_WORDS * XLEN
)
(
    input  wire               clk_i,
    input  wire               rst_i,
    input  wire               strobe_i,        // One-cycle request pulse
    input  wire               op_i,            // MEM_WRITE or MEM_READ
    input  wire [XLEN-1:0]    addr_i,          // Line address
    input  wire [LINE_W-1:0]  wdata_i,
    output logic [LINE_W-1:0] rdata_o,
    output logic              ready_o,         // One-cycle response pulse
    output logic [XLEN-1:0]   last_wr_addr_o,  // Log of the last write
    output logic [LINE_W-1:0] last_wr_data_o,
    output int unsigned       rd_count_o,
    output int unsigned       wr_count_o
);

    logic [31:0]       mem [MEM_WORDS];
    logic              busy_q;     // One transaction in flight
    logic              op_q;
    logic [XLEN-1:0]   addr_q;
    logic [LINE_W-1:0] wdata_q;
    int unsigned       wait_q;     // Cycles left before the answer
    logic [XLEN-3:0]   base;       // Word index of the line start

    assign base = addr_q[XLEN-1:2];

    // Word at byte address A holds A XOR PATTERN
    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'(i * 4) ^ PATTERN;
        ready_o = 1'b0;
        rdata_o = '0;
        busy_q  = 1'b0;
    end

    always @(posedge clk_i)
    begin
        ready_o <= 1'b0;
        if (rst_i)
        begin
            busy_q         <= 1'b0;
            rd_count_o     <= 0;
            wr_count_o     <= 0;
            last_wr_addr_o <= '0;
            last_wr_data_o <= '0;
        end
        else if (!busy_q)
        begin
            if (strobe_i)
            begin
                busy_q  <= 1'b1;
                op_q    <= op_i;
                addr_q  <= addr_i;
                wdata_q <= wdata_i;
                wait_q  <= 1 + $urandom % 6;  // Latency of 1 to 6 cycles
            end
        end
        else if (wait_q > 1)
            wait_q <= wait_q - 1;
        else
        begin
            busy_q  <= 1'b0;
            ready_o <= 1'b1;
            for (int w = 0; w < LINE_WORDS; w++)
            begin
                if (op_q == MEM_WRITE)
                    mem[base + w] <= wdata_q[w*XLEN +: XLEN];
                else
                    rdata_o[w*XLEN +: XLEN] <= mem[base + w];  // Word 0 in the low bits
            end
            if (op_q == MEM_WRITE)
            begin
                last_wr_addr_o <= addr_q;
                last_wr_data_o <= wdata_q;
                wr_count_o     <= wr_count_o + 1;
            end
            else
                rd_count_o <= rd_count_o + 1;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_dcache.sv ====
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int          N_WAYS      = 4;
    localparam int          N_SETS      = 16;
    localparam int          LINE_WORDS  = 4;
    localparam int          LINE_W      = LINE_WORDS * XLEN;
    localparam logic [31:0] PATTERN     = 32'h5A3C_96E1;
    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DLY   = 5;    // Input skew after the rising edge
    localparam int          SEED        = 59090;
    localparam int          N_REQUESTS  = 240;  // Requests of all tests with margin
    localparam int          MISS_CYCLES = 32;   // Write-back plus refill at top latency
    localparam int          WATCHDOG_TIME =
        (N_REQUESTS * MISS_CYCLES + N_SETS + 50) * CLK_PERIOD;

    logic               clk;
    logic               rst;
    logic               p_strobe;
    logic               p_rw;
    logic [XLEN-1:0]    p_addr;
    logic [XLEN-1:0]    p_wdata;
    logic [XLEN/8-1:0]  p_be;
    logic [XLEN-1:0]    p_rdata;
    logic               p_ready;
    logic               m_strobe;
    mem_op_e            m_op;
    logic [XLEN-1:0]    m_addr;
    logic [LINE_W-1:0]  m_wdata;
    logic [LINE_W-1:0]  m_rdata;
    logic               m_ready;
    logic [XLEN-1:0]    last_wr_addr;
    logic [LINE_W-1:0]  last_wr_data;
    int unsigned        rd_count;
    int unsigned        wr_count;

    logic [7:0] shadow [logic [XLEN-1:0]];  // Stored bytes by byte address

    dcache_top #(.N_WAYS(N_WAYS), .N_SETS(N_SETS), .LINE_WORDS(LINE_WORDS)) uut (
        .clk_i(clk), .rst_i(rst),
        .p_strobe_i(p_strobe), .p_rw_i(p_rw), .p_addr_i(p_addr), .p_wdata_i(p_wdata),
        .p_be_i(p_be), .p_rdata_o(p_rdata), .p_ready_o(p_ready),
        .m_strobe_o(m_strobe), .m_op_o(m_op), .m_addr_o(m_addr), .m_wdata_o(m_wdata),
        .m_rdata_i(m_rdata), .m_ready_i(m_ready)
    );

    tb_mem_model #(.LINE_WORDS(LINE_WORDS), .PATTERN(PATTERN)) u_mem (
        .clk_i(clk), .rst_i(rst),
        .strobe_i(m_strobe), .op_i(m_op), .addr_i(m_addr), .wdata_i(m_wdata),
        .rdata_o(m_rdata), .ready_o(m_ready),
        .last_wr_addr_o(last_wr_addr), .last_wr_data_o(last_wr_data),
        .rd_count_o(rd_count), .wr_count_o(wr_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // Reference model
    // ============================================================
    function automatic logic [XLEN-1:0] make_addr(input int tag, input int set, input int word);
        return XLEN'((((tag * N_SETS) + set) * LINE_WORDS + word) * 4);
    endfunction

    function automatic logic [7:0] expected_byte(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] init_word;
        init_word = {addr[XLEN-1:2], 2'b00} ^ PATTERN;  // Untouched memory pattern
        if (shadow.exists(addr))
            return shadow[addr];
        return init_word[8*addr[1:0] +: 8];
    endfunction

    function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        for (int b = 0; b < XLEN/8; b++)
            word[8*b +: 8] = expected_byte({addr[XLEN-1:2], 2'(b)});
        return word;
    endfunction

    function automatic logic [LINE_W-1:0] expected_line(input logic [XLEN-1:0] addr);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < LINE_WORDS; w++)
            line[w*XLEN +: XLEN] = expected_word(addr + XLEN'(4 * w));  // Little-endian words
        return line;
    endfunction

    task automatic check_equal(input logic [LINE_W-1:0] actual,
                               input logic [LINE_W-1:0] expected, input string what);
        if (actual !== expected)
        begin
            $display("MISMATCH at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value check failed");
        end
    endtask

    // ============================================================
    // Processor port driver
    // ============================================================
    // Starts and ends DRIVE_DLY after a rising edge
    task automatic access(input logic rw, input logic [XLEN-1:0] addr,
                          input logic [XLEN-1:0] wdata, input logic [XLEN/8-1:0] be,
                          output logic [XLEN-1:0] rdata, output int cycles);
        p_strobe = 1'b1;
        p_rw     = rw;
        p_addr   = addr;
        p_wdata  = wdata;
        p_be     = be;
        cycles   = 0;
        do
        begin
            @(posedge clk);
            cycles++;        // Edges from acceptance on
            @(negedge clk);  // Ready and read data are settled here
        end
        while (!p_ready);
        rdata = p_rdata;
        @(posedge clk);
        #DRIVE_DLY;
        p_strobe = 1'b0;
    endtask

    task automatic load_check(input logic [XLEN-1:0] addr, output int cycles);
        logic [XLEN-1:0] rdata;
        access(1'b0, addr, '0, '0, rdata, cycles);
        check_equal(rdata, expected_word(addr), $sformatf("load from %h", addr));
    endtask

    task automatic store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                         input logic [XLEN/8-1:0] be, output int cycles);
        logic [XLEN-1:0] rdata;
        access(1'b1, addr, wdata, be, rdata, cycles);
        for (int b = 0; b < XLEN/8; b++)
            if (be[b])
                shadow[{addr[XLEN-1:2], 2'(b)}] = wdata[8*b +: 8];  // Enabled lanes only
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic read_miss_then_hit();
        int unsigned rd0;
        int unsigned wr0;
        int          cycles;
        rd0 = rd_count;
        wr0 = wr_count;
        load_check(make_addr(1, 2, 1), cycles);
        check_equal(rd_count, rd0 + 1, "memory reads after cold miss");
        load_check(make_addr(1, 2, 3), cycles);
        check_equal(rd_count, rd0 + 1, "memory reads after read hit");
        check_equal(wr_count, wr0, "memory writes after read miss and hit");
        check_equal(cycles, 1, "read hit latency");
    endtask

    task automatic store_hit_merge();
        int unsigned wr0;
        int          cycles;
        wr0 = wr_count;
        store(make_addr(1, 2, 0), 32'h0000_AB00, 4'b0010, cycles);  // Byte lane 1
        check_equal(cycles, 1, "store hit latency");
        store(make_addr(1, 2, 2), 32'hBEEF_0000, 4'b1100, cycles);  // Upper halfword
        store(make_addr(1, 2, 3), 32'h1234_5678, 4'b1111, cycles);
        load_check(make_addr(1, 2, 0), cycles);
        load_check(make_addr(1, 2, 2), cycles);
        load_check(make_addr(1, 2, 3), cycles);
        check_equal(wr_count, wr0, "memory writes after store hits");
    endtask

    task automatic write_allocate_miss();
        int unsigned rd0;
        int unsigned wr0;
        int          cycles;
        rd0 = rd_count;
        wr0 = wr_count;
        store(make_addr(2, 5, 2), 32'hCAFE_F00D, 4'b0011, cycles);  // Low halfword into refill
        check_equal(rd_count, rd0 + 1, "memory reads after store miss");
        check_equal(wr_count, wr0, "memory writes after store miss");
        load_check(make_addr(2, 5, 2), cycles);
        load_check(make_addr(2, 5, 1), cycles);  // Neighbour word from the refill
    endtask

    task automatic dirty_eviction();
        int unsigned wr0;
        int          cycles;
        store(make_addr(3, 7, 1), 32'h0000_0077, 4'b0001, cycles);  // Dirty line in way 0
        store(make_addr(4, 7, 2), 32'h9988_0000, 4'b1100, cycles);  // Dirty line in way 1
        load_check(make_addr(5, 7, 0), cycles);
        load_check(make_addr(6, 7, 3), cycles);
        wr0 = wr_count;
        load_check(make_addr(7, 7, 0), cycles);  // Evicts tag 3
        check_equal(wr_count, wr0 + 1, "write-backs after first eviction");
        check_equal(last_wr_addr, make_addr(3, 7, 0), "write-back address of tag 3");
        check_equal(last_wr_data, expected_line(make_addr(3, 7, 0)), "write-back line of tag 3");
        load_check(make_addr(8, 7, 1), cycles);  // Evicts tag 4
        check_equal(wr_count, wr0 + 2, "write-backs after second eviction");
        check_equal(last_wr_addr, make_addr(4, 7, 0), "write-back address of tag 4");
        check_equal(last_wr_data, expected_line(make_addr(4, 7, 0)), "write-back line of tag 4");
    endtask

    task automatic clean_eviction();
        int unsigned rd0;
        int unsigned wr0;
        int          cycles;
        wr0 = wr_count;
        for (int t = 10; t < 14; t++)
            load_check(make_addr(t, 9, t % LINE_WORDS), cycles);
        load_check(make_addr(14, 9, 0), cycles);  // Evicts clean tag 10
        check_equal(wr_count, wr0, "memory writes after clean eviction");
        rd0 = rd_count;
        load_check(make_addr(10, 9, 2), cycles);
        check_equal(rd_count, rd0 + 1, "memory reads when reloading tag 10");
    endtask

    task automatic random_traffic();
        logic [XLEN-1:0]   addr;
        logic [XLEN/8-1:0] be;
        int                lane;
        int                cycles;
        for (int i = 0; i < 200; i++)
        begin
            // Six tags over two sets overflow four ways
            addr = make_addr(20 + $urandom % 6, $urandom % 2, $urandom % LINE_WORDS);
            if ($urandom % 2)
                load_check(addr, cycles);
            else
            begin
                lane = $urandom % 4;
                case ($urandom % 3)
                    0:       be = 4'b0001 << lane;
                    1:       be = (lane < 2) ? 4'b0011 : 4'b1100;
                    default: be = 4'b1111;
                endcase
                store(addr, $urandom, be, cycles);
            end
        end
    endtask

    // ============================================================
    // Run control
    // ============================================================
    initial
    begin
        #(WATCHDOG_TIME);
        $display("ERROR: watchdog expired, the cache stopped answering requests");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog timeout");
    end

    initial
    begin
        void'($urandom(SEED));
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_addr   = '0;
        p_wdata  = '0;
        p_be     = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;  // First request waits out the init sweep
        read_miss_then_hit();
        store_hit_merge();
        write_allocate_miss();
        dirty_eviction();
        clean_eviction();
        random_traffic();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/dcache_pkg.sv
hw/dcache_fifo_repl.sv
hw/dcache_way_array.sv
hw/dcache_word_merge.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - hw/dcache_pkg.sv
      - hw/dcache_fifo_repl.sv
      - hw/dcache_way_array.sv
      - hw/dcache_word_merge.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_top.sv
  - target: test
    files:
      - tb/tb_mem_model.sv
      - tb/tb_dcache.sv
